// File: design/decode_stage.sv
// decode stage: control decode, forwarded operands, beq resolution and the decode/execute register
`default_nettype none

module decode_stage (
    input  logic                       SYS_clk,
    input  logic                       SYS_reset,
    input  logic                       stall,
    input  isa_pkg::instr_u            fetch_instr,
    input  logic [pipe_pkg::PC_W-1:0]  fetch_pc,
    input  pipe_pkg::fwd_sel_t         fwd,
    input  logic [isa_pkg::WORD_W-1:0] mem_alu_result,
    input  pipe_pkg::commit_t          commit,
    output isa_pkg::instr_u            decode_instr,
    output logic                       branch_taken,
    output logic [pipe_pkg::PC_W-1:0]  branch_target,
    output pipe_pkg::de_reg_t          de_reg
);

    import isa_pkg::*;
    import pipe_pkg::*;

    ctrl_t                 ctrl;
    logic [WORD_W-1:0]     rs_data;
    logic [WORD_W-1:0]     rt_data;
    logic [WORD_W-1:0]     operand_a;
    logic [WORD_W-1:0]     operand_b;
    logic [WORD_W-1:0]     imm_ext;
    logic [REG_ADDR_W-1:0] dest;
    logic                  is_beq;

    assign decode_instr = fetch_instr;

    always_comb
    begin
        ctrl = '0;
        case (fetch_instr.r.opcode)
            OP_RTYPE:
            begin
                ctrl.reg_write = 1'b1;
                case (fetch_instr.r.funct)
                    FN_ADD:  ctrl.alu_op = ALU_ADD;
                    FN_SUB:  ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: ctrl.reg_write = 1'b0;  // nop lands here
                endcase
            end
            OP_ADDI:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_LW:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_SW:
            begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            default: ctrl = '0;  // beq needs no downstream control
        endcase
    end

    register_file register_file_i (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (fetch_instr.r.rs),
        .rt_addr   (fetch_instr.r.rt),
        .write     (commit),
        .rs_data   (rs_data),
        .rt_data   (rt_data)
    );

    assign operand_a = fwd.forward_a ? mem_alu_result : rs_data;
    assign operand_b = fwd.forward_b ? mem_alu_result : rt_data;
    assign imm_ext   = {{16{fetch_instr.i.imm[15]}}, fetch_instr.i.imm};
    assign dest      = (fetch_instr.r.opcode == OP_RTYPE) ? fetch_instr.r.rd : fetch_instr.i.rt;

    // operands are only trusted once the hazard unit lets decode proceed
    assign is_beq        = (fetch_instr.i.opcode == OP_BEQ);
    assign branch_taken  = is_beq && (operand_a == operand_b) && !stall;
    assign branch_target = fetch_pc + 1'b1 + imm_ext[PC_W-1:0];

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            de_reg <= '0;
        else
        begin
            de_reg.valid     <= !stall && (fetch_instr != '0);  // bubble on stall
            de_reg.ctrl      <= ctrl;
            de_reg.operand_a <= operand_a;
            de_reg.operand_b <= operand_b;
            de_reg.imm       <= imm_ext;
            de_reg.dest      <= dest;
        end
    end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
// execute stage: ALU with immediate select and the execute/memory register
`default_nettype none

module execute_stage (
    input  logic              SYS_clk,
    input  logic              SYS_reset,
    input  pipe_pkg::de_reg_t de_reg,
    output isa_pkg::instr_u   ex_instr,
    output pipe_pkg::em_reg_t em_reg
);

    import isa_pkg::*;

    logic [WORD_W-1:0] alu_b;
    logic [WORD_W-1:0] alu_result;

    // hazard view of this stage, only the destination is needed
    always_comb
    begin
        ex_instr          = '0;
        ex_instr.r.opcode = OP_RTYPE;
        ex_instr.r.rd     = de_reg.dest;
    end

    assign alu_b = de_reg.ctrl.alu_src_imm ? de_reg.imm : de_reg.operand_b;

    always_comb
    begin
        case (de_reg.ctrl.alu_op)
            ALU_SUB: alu_result = de_reg.operand_a - alu_b;
            ALU_AND: alu_result = de_reg.operand_a & alu_b;
            ALU_OR:  alu_result = de_reg.operand_a | alu_b;
            ALU_SLT: alu_result = {{(WORD_W-1){1'b0}}, $signed(de_reg.operand_a) < $signed(alu_b)};
            default: alu_result = de_reg.operand_a + alu_b;  // add, also addresses
        endcase
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            em_reg <= '0;
        else
        begin
            em_reg.valid      <= de_reg.valid;
            em_reg.ctrl       <= de_reg.ctrl;
            em_reg.alu_result <= alu_result;
            em_reg.store_data <= de_reg.operand_b;
            em_reg.dest       <= de_reg.dest;
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
// fetch stage: PC, loadable instruction memory and the fetch/decode register
`default_nettype none

module fetch_stage (
    input  logic                      SYS_clk,
    input  logic                      SYS_reset,
    input  logic                      run,
    input  pipe_pkg::imem_load_t      imem_load,
    input  logic                      stall,
    input  logic                      branch_taken,
    input  logic [pipe_pkg::PC_W-1:0] branch_target,
    output isa_pkg::instr_u           fetch_instr,
    output logic [pipe_pkg::PC_W-1:0] fetch_pc
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic [WORD_W-1:0] imem [IMEM_DEPTH];
    logic [PC_W-1:0]   pc;

    always_ff @(posedge SYS_clk)
    begin
        if (!run && imem_load.valid)  // loader owns memory while halted
            imem[imem_load.addr] <= imem_load.word;
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            pc          <= '0;
            fetch_instr <= '0;
            fetch_pc    <= '0;
        end
        else if (!run)
        begin
            pc          <= '0;  // parked at program start
            fetch_instr <= '0;
        end
        else if (!stall)
        begin
            if (branch_taken)
            begin
                pc          <= branch_target;
                fetch_instr <= '0;  // kill the word behind the branch
            end
            else
            begin
                pc          <= pc + 1'b1;
                fetch_instr <= imem[pc];
            end
            fetch_pc <= pc;
        end
    end

endmodule

`default_nettype wire

// File: design/hazard_unit.sv
// hazard unit: stalls decode on execute or load dependencies, else forwards the memory ALU result
`default_nettype none

module hazard_unit (
    input  isa_pkg::instr_u                decode_instr,
    input  isa_pkg::instr_u                ex_instr,
    input  pipe_pkg::ctrl_t                ex_ctrl,
    input  logic                           ex_valid,
    input  logic [isa_pkg::REG_ADDR_W-1:0] mem_dest,
    input  pipe_pkg::ctrl_t                mem_ctrl,
    input  logic                           mem_valid,
    output logic                           stall,
    output pipe_pkg::fwd_sel_t             fwd
);

    import isa_pkg::*;

    logic                  reads_rs;
    logic                  reads_rt;
    logic [REG_ADDR_W-1:0] ex_dest;
    logic                  ex_writes;
    logic                  mem_writes;
    logic                  ex_hit;
    logic                  mem_hit_a;
    logic                  mem_hit_b;

    always_comb
    begin
        reads_rs = 1'b0;
        reads_rt = 1'b0;
        case (decode_instr.r.opcode)
            OP_RTYPE, OP_SW, OP_BEQ:
            begin
                reads_rs = 1'b1;
                reads_rt = 1'b1;
            end
            OP_ADDI, OP_LW: reads_rs = 1'b1;
            default:        reads_rs = 1'b0;
        endcase
    end

    assign ex_dest    = ex_instr.r.rd;  // execute reports its destination as rd
    assign ex_writes  = ex_valid && ex_ctrl.reg_write && ex_dest != '0;
    assign mem_writes = mem_valid && mem_ctrl.reg_write && mem_dest != '0;

    assign ex_hit    = ex_writes && ((reads_rs && ex_dest == decode_instr.r.rs) ||
                                     (reads_rt && ex_dest == decode_instr.r.rt));
    assign mem_hit_a = mem_writes && reads_rs && mem_dest == decode_instr.r.rs;
    assign mem_hit_b = mem_writes && reads_rt && mem_dest == decode_instr.r.rt;

    // load data only exists after memory, so a load one stage ahead still stalls
    assign stall         = ex_hit || (mem_ctrl.mem_read && (mem_hit_a || mem_hit_b));
    assign fwd.forward_a = mem_hit_a && !mem_ctrl.mem_read;
    assign fwd.forward_b = mem_hit_b && !mem_ctrl.mem_read;

endmodule

`default_nettype wire

// File: design/isa_pkg.sv
// isa package: instruction formats, opcodes, function codes and ALU operations of the MIPS subset
`default_nettype none

package isa_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    typedef struct packed {
        opcode_e               opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;  // no shifts in this subset
        funct_e                funct;
    } r_format_t;

    typedef struct packed {
        opcode_e               opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm;    // sign-extended by decode
    } i_format_t;

    // one instruction word, read through either format; all zero is a nop
    typedef union packed {
        r_format_t r;
        i_format_t i;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

endpackage

`default_nettype wire

// File: design/memory_writeback.sv
// memory and writeback: data memory, memory/writeback register and the commit port
`default_nettype none

module memory_writeback (
    input  logic                           SYS_clk,
    input  logic                           SYS_reset,
    input  pipe_pkg::em_reg_t              em_reg,
    output logic [isa_pkg::REG_ADDR_W-1:0] mem_dest,
    output pipe_pkg::ctrl_t                mem_ctrl,
    output logic                           mem_valid,
    output logic [isa_pkg::WORD_W-1:0]     mem_alu_result,
    output pipe_pkg::commit_t              commit
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic [WORD_W-1:0]      dmem [DMEM_DEPTH];
    logic [DMEM_ADDR_W-1:0] dmem_addr;
    logic [WORD_W-1:0]      load_data;
    logic                   store_en;

    assign mem_dest       = em_reg.dest;
    assign mem_ctrl       = em_reg.ctrl;
    assign mem_valid      = em_reg.valid;
    assign mem_alu_result = em_reg.alu_result;

    assign dmem_addr = em_reg.alu_result[DMEM_ADDR_W+1:2];  // word index, bits 7:2
    assign load_data = dmem[dmem_addr];
    assign store_en  = em_reg.valid && em_reg.ctrl.mem_write;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < DMEM_DEPTH; i++)
                dmem[i] <= '0;  // unwritten words read as zero
        end
        else if (store_en)
            dmem[dmem_addr] <= em_reg.store_data;
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            commit <= '0;
        else
        begin
            commit.valid <= em_reg.valid && em_reg.ctrl.reg_write && em_reg.dest != '0;
            commit.rd    <= em_reg.dest;
            commit.data  <= em_reg.ctrl.mem_read ? load_data : em_reg.alu_result;
        end
    end

endmodule

`default_nettype wire

// File: design/mips_pipeline.sv
// MIPS pipeline top: five in-order stages, hazard unit and the commit port
`default_nettype none

module mips_pipeline (
    input  logic                 SYS_clk,
    input  logic                 SYS_reset,
    input  logic                 run,
    input  pipe_pkg::imem_load_t imem_load,
    output pipe_pkg::commit_t    commit
);

    import isa_pkg::*;
    import pipe_pkg::*;

    instr_u                fetch_instr;
    logic [PC_W-1:0]       fetch_pc;
    instr_u                decode_instr;
    instr_u                ex_instr;
    logic                  branch_taken;
    logic [PC_W-1:0]       branch_target;
    logic                  stall;
    fwd_sel_t              fwd;
    de_reg_t               de_reg;
    em_reg_t               em_reg;
    logic [REG_ADDR_W-1:0] mem_dest;
    ctrl_t                 mem_ctrl;
    logic                  mem_valid;
    logic [WORD_W-1:0]     mem_alu_result;

    fetch_stage fetch_stage_i (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .run           (run),
        .imem_load     (imem_load),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .fetch_instr   (fetch_instr),
        .fetch_pc      (fetch_pc)
    );

    decode_stage decode_stage_i (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .stall          (stall),
        .fetch_instr    (fetch_instr),
        .fetch_pc       (fetch_pc),
        .fwd            (fwd),
        .mem_alu_result (mem_alu_result),
        .commit         (commit),         // register file write port
        .decode_instr   (decode_instr),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .de_reg         (de_reg)
    );

    hazard_unit hazard_unit_i (
        .decode_instr (decode_instr),
        .ex_instr     (ex_instr),
        .ex_ctrl      (de_reg.ctrl),
        .ex_valid     (de_reg.valid),
        .mem_dest     (mem_dest),
        .mem_ctrl     (mem_ctrl),
        .mem_valid    (mem_valid),
        .stall        (stall),
        .fwd          (fwd)
    );

    execute_stage execute_stage_i (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .de_reg    (de_reg),
        .ex_instr  (ex_instr),
        .em_reg    (em_reg)
    );

    memory_writeback memory_writeback_i (
        .SYS_clk        (SYS_clk),
        .SYS_reset      (SYS_reset),
        .em_reg         (em_reg),
        .mem_dest       (mem_dest),
        .mem_ctrl       (mem_ctrl),
        .mem_valid      (mem_valid),
        .mem_alu_result (mem_alu_result),
        .commit         (commit)
    );

endmodule

`default_nettype wire

// File: design/pipe_pkg.sv
// pipeline package: memory sizes, control bundle and the stage register layouts
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    localparam int PC_W        = 8;             // word-addressed PC
    localparam int IMEM_DEPTH  = 1 << PC_W;
    localparam int DMEM_DEPTH  = 64;
    localparam int DMEM_ADDR_W = $clog2(DMEM_DEPTH);

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        alu_op_e alu_op;
        logic    spare;  // always zero
    } ctrl_t;

    typedef struct packed {
        logic              valid;
        logic [PC_W-1:0]   addr;
        logic [WORD_W-1:0] word;
    } imem_load_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [WORD_W-1:0]     operand_a;
        logic [WORD_W-1:0]     operand_b;  // rt value, also store data
        logic [WORD_W-1:0]     imm;
        logic [REG_ADDR_W-1:0] dest;
    } de_reg_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [WORD_W-1:0]     alu_result;
        logic [WORD_W-1:0]     store_data;
        logic [REG_ADDR_W-1:0] dest;
    } em_reg_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [WORD_W-1:0]     data;
    } commit_t;

    typedef struct packed {
        logic forward_a;
        logic forward_b;
    } fwd_sel_t;

endpackage

`default_nettype wire

// File: design/register_file.sv
// register file: 32 x 32, two read ports with write-through, register 0 fixed at zero
`default_nettype none

module register_file (
    input  logic                           SYS_clk,
    input  logic                           SYS_reset,
    input  logic [isa_pkg::REG_ADDR_W-1:0] rs_addr,
    input  logic [isa_pkg::REG_ADDR_W-1:0] rt_addr,
    input  pipe_pkg::commit_t              write,
    output logic [isa_pkg::WORD_W-1:0]     rs_data,
    output logic [isa_pkg::WORD_W-1:0]     rt_data
);

    import isa_pkg::*;

    logic [WORD_W-1:0] regs [1 << REG_ADDR_W];

    function automatic logic [WORD_W-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        if (write.valid && write.rd == addr)
            return write.data;  // same-cycle writeback
        return regs[addr];
    endfunction

    always_comb
    begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < $size(regs); i++)
                regs[i] <= '0;
        end
        else if (write.valid && write.rd != '0)
            regs[write.rd] <= write.data;
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it; the exit status is the simulator's
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module tb_mips_pipeline -o tb_mips_pipeline
./obj_dir/tb_mips_pipeline

// File: test/mips_pipeline_assertions.sv
// pipeline control checks bound into the MIPS pipeline top
`default_nettype none

module mips_pipeline_assertions (
    input logic              SYS_clk,
    input logic              SYS_reset,
    input logic              stall,
    input pipe_pkg::commit_t commit
);

    // execute hazard then load-use is the longest wait
    stall_bounded: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(stall && $past(stall) && $past(stall, 2)))
        else $error("stall held for more than two cycles");

    commit_rd_nonzero: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        commit.valid |-> commit.rd != '0)
        else $error("commit reports a write to register zero");

endmodule

bind mips_pipeline mips_pipeline_assertions mips_pipeline_assertions_i (
    .SYS_clk   (SYS_clk),
    .SYS_reset (SYS_reset),
    .stall     (stall),
    .commit    (commit)
);

`default_nettype wire

// File: test/tb_mips_pipeline.sv
// testbench running random programs on the MIPS pipeline against an architectural model
`default_nettype none

module tb_mips_pipeline;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int unsigned SEED = 32'hb3dc;
    localparam int ROUNDS        = 20;
    localparam int PROG_LEN      = 48;
    localparam int RESET_CYCLES  = 10;
    localparam int RUN_CYCLES    = 120;
    localparam int DRAIN_CYCLES  = 2;
    localparam int ROUND_CYCLES  = RESET_CYCLES + IMEM_DEPTH + 2 + RUN_CYCLES + DRAIN_CYCLES;
    localparam int TIMEOUT       = ROUNDS * ROUND_CYCLES + 200;

    logic       SYS_clk = 1'b0;
    logic       SYS_reset;
    logic       run;
    imem_load_t imem_load;
    commit_t    commit;

    logic [WORD_W-1:0] program_words [IMEM_DEPTH];
    commit_t           expected [$];  // model commits of the current round
    int                round_idx;
    int                commit_idx = 0;
    int                cycle_count = 0;

    mips_pipeline mips_pipeline_i (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .run       (run),
        .imem_load (imem_load),
        .commit    (commit)
    );

    always #4 SYS_clk = ~SYS_clk;

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic instr_u random_instr(input int idx);
        instr_u      ins;
        logic [31:0] r;
        int          kind;
        int          max_off;
        ins      = '0;
        r        = $urandom;
        kind     = int'($urandom_range(8, 0));
        max_off  = (PROG_LEN - 1 - idx < 7) ? PROG_LEN - 1 - idx : 7;  // land on or before the pad
        ins.r.rs = 5'($urandom_range(7, 0));
        ins.r.rt = 5'($urandom_range(7, 0));
        case (kind)
            0, 1, 2, 3, 4:
            begin
                ins.r.opcode = OP_RTYPE;
                ins.r.rd     = 5'($urandom_range(7, 0));  // r0 as a destination too
                case (kind)
                    0:       ins.r.funct = FN_ADD;
                    1:       ins.r.funct = FN_SUB;
                    2:       ins.r.funct = FN_AND;
                    3:       ins.r.funct = FN_OR;
                    default: ins.r.funct = FN_SLT;
                endcase
            end
            5:
            begin
                ins.i.opcode = OP_ADDI;
                ins.i.imm    = r[31] ? r[15:0] : {{13{r[2]}}, r[2:0]};  // small values help beq
            end
            6, 7:
            begin
                if (kind == 6)
                    ins.i.opcode = OP_LW;
                else
                    ins.i.opcode = OP_SW;
                ins.i.rs  = '0;
                ins.i.imm = {8'h00, r[5:0], 2'b00};  // word aligned inside data memory
            end
            default:
            begin
                ins.i.opcode = OP_BEQ;
                if (r[16])
                    ins.i.rt = ins.i.rs;  // forces a taken branch
                ins.i.imm = 16'($urandom_range(max_off, 0));
            end
        endcase
        return ins;
    endfunction

    function automatic void build_program();
        for (int a = 0; a < IMEM_DEPTH; a++)
        begin
            if (a < PROG_LEN)
                program_words[a] = random_instr(a);
            else
                program_words[a] = '0;
        end
    endfunction

    // architectural model stepping one instruction at a time
    function automatic void run_model();
        logic [WORD_W-1:0]     regs [32];
        logic [WORD_W-1:0]     mem [DMEM_DEPTH];
        instr_u                ins;
        commit_t               entry;
        logic [WORD_W-1:0]     a;
        logic [WORD_W-1:0]     b;
        logic [WORD_W-1:0]     imm;
        logic [WORD_W-1:0]     addr;
        logic [WORD_W-1:0]     result;
        logic [REG_ADDR_W-1:0] dest;
        logic                  writes;
        int                    pc;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < DMEM_DEPTH; i++)
            mem[i] = '0;
        expected.delete();
        pc = 0;
        while (pc < PROG_LEN)
        begin
            ins    = program_words[pc];
            a      = regs[ins.i.rs];
            b      = regs[ins.i.rt];
            imm    = {{16{ins.i.imm[15]}}, ins.i.imm};
            addr   = a + imm;
            dest   = ins.i.rt;
            writes = 1'b0;
            result = '0;
            pc     = pc + 1;
            case (ins.i.opcode)
                OP_RTYPE:
                begin
                    dest   = ins.r.rd;
                    writes = 1'b1;
                    case (ins.r.funct)
                        FN_ADD:  result = a + b;
                        FN_SUB:  result = a - b;
                        FN_AND:  result = a & b;
                        FN_OR:   result = a | b;
                        default: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    endcase
                end
                OP_ADDI:
                begin
                    writes = 1'b1;
                    result = a + imm;
                end
                OP_LW:
                begin
                    writes = 1'b1;
                    result = mem[addr[7:2]];
                end
                OP_SW:   mem[addr[7:2]] = b;
                default: if (a == b) pc = pc + int'($signed(ins.i.imm));  // beq
            endcase
            if (writes && dest != '0)  // r0 writes vanish
            begin
                regs[dest]  = result;
                entry.valid = 1'b1;
                entry.rd    = dest;
                entry.data  = result;
                expected.push_back(entry);
            end
        end
    endfunction

    task automatic apply_reset();
        @(posedge SYS_clk);
        SYS_reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge SYS_clk);
        SYS_reset <= 1'b0;
    endtask

    task automatic load_program();
        imem_load_t word_load;
        for (int a = 0; a < IMEM_DEPTH; a++)
        begin
            word_load.valid = 1'b1;
            word_load.addr  = PC_W'(a);
            word_load.word  = program_words[a];
            @(posedge SYS_clk);
            imem_load <= word_load;
        end
        @(posedge SYS_clk);
        imem_load <= '0;
    endtask

    always @(posedge SYS_clk)
    begin
        cycle_count <= cycle_count + 1;
        assert (cycle_count < TIMEOUT)
        else stop_with_failure($sformatf("timeout after %0d cycles", cycle_count));
    end

    // commits compared against the model in program order
    always @(negedge SYS_clk)
    begin
        if (SYS_reset)
            commit_idx = 0;
        else if (commit.valid)
        begin
            assert (run)
            else stop_with_failure($sformatf("commit to r%0d while run is low", commit.rd));
            assert (commit_idx < expected.size())
            else stop_with_failure($sformatf("round %0d has more commits than the model's %0d",
                                             round_idx, expected.size()));
            assert (commit.rd == expected[commit_idx].rd &&
                    commit.data == expected[commit_idx].data)
            else stop_with_failure($sformatf(
                "Fail round %0d commit %0d: expected rd=%0d data=%h, actual rd=%0d data=%h",
                round_idx, commit_idx, expected[commit_idx].rd, expected[commit_idx].data,
                commit.rd, commit.data));
            commit_idx++;
        end
    end

    initial
    begin
        SYS_reset = 1'b1;
        run       = 1'b0;
        imem_load = '0;
        void'($urandom(SEED));
        for (int round = 0; round < ROUNDS; round++)
        begin
            round_idx = round;
            build_program();
            run_model();
            apply_reset();
            load_program();
            @(posedge SYS_clk);
            run <= 1'b1;
            repeat (RUN_CYCLES) @(posedge SYS_clk);
            run <= 1'b0;
            repeat (DRAIN_CYCLES) @(posedge SYS_clk);
            assert (commit_idx == expected.size())
            else stop_with_failure($sformatf(
                "Fail round %0d commit count: expected %0d, actual %0d",
                round_idx, expected.size(), commit_idx));
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/register_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/hazard_unit.sv
design/execute_stage.sv
design/memory_writeback.sv
design/mips_pipeline.sv
test/mips_pipeline_assertions.sv
test/tb_mips_pipeline.sv
